//--- ahb_dual_mem.f
hdl/ahb_mem_pkg.sv
hdl/ahb_port_ctrl.sv
hdl/byte_lane_memory.sv
hdl/sim_irq_regs.sv
hdl/ahb_dual_mem.sv
verification/tb_clk_gen.sv
verification/tb_checker.sv
verification/tb_ahb_dual_mem.sv

//--- Bender.yml
package:
  name: ahb_dual_mem

sources:
  - hdl/ahb_mem_pkg.sv
  - hdl/ahb_port_ctrl.sv
  - hdl/byte_lane_memory.sv
  - hdl/sim_irq_regs.sv
  - hdl/ahb_dual_mem.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_checker.sv
      - verification/tb_ahb_dual_mem.sv

//--- verification/tb_ahb_dual_mem.sv
/*
 * Testbench top for the dual-port AHB memory.
 * Random and directed transfers on both ports, xorshift stimulus.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_dual_mem;

import ahb_mem_pkg::*;

localparam int RESET_CYCLES  = 4;
localparam int IDLE_CYCLES   = 8;
localparam int RANDOM_CYCLES = 800;
localparam int FWD_ROUNDS    = 64;
localparam int IRQ_ROUNDS    = 32;
localparam int ERR_ROUNDS    = 48;
localparam int DRAIN_CYCLES  = 2;
localparam int TEST_COUNT    = 5;
localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + RANDOM_CYCLES + 2 * FWD_ROUNDS
                             + 4 * IRQ_ROUNDS + 3 * ERR_ROUNDS + TEST_COUNT * DRAIN_CYCLES;
localparam int WATCHDOG_NS   = TOTAL_CYCLES * 4 + 200;

logic                     clk;
logic                     rst_n;
ahb_req_t                 imem_req;
ahb_req_t                 dmem_req;
word_t                    dmem_hwdata;
word_t                    imem_hrdata;
word_t                    dmem_hrdata;
logic                     imem_hresp;
logic                     dmem_hresp;
logic                     soft_irq;
logic [IRQ_LINES_NUM-1:0] irq_lines;
logic [31:0]              rng_state;
// Data for the write whose address phase was driven last
word_t                    wdata_next;

tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
);

ahb_dual_mem u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_req    (imem_req),
    .imem_hrdata (imem_hrdata),
    .imem_hresp  (imem_hresp),
    .dmem_req    (dmem_req),
    .dmem_hwdata (dmem_hwdata),
    .dmem_hrdata (dmem_hrdata),
    .dmem_hresp  (dmem_hresp),
    .soft_irq    (soft_irq),
    .irq_lines   (irq_lines)
);

tb_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_req    (imem_req),
    .dmem_req    (dmem_req),
    .dmem_hwdata (dmem_hwdata),
    .imem_hrdata (imem_hrdata),
    .imem_hresp  (imem_hresp),
    .dmem_hrdata (dmem_hrdata),
    .dmem_hresp  (dmem_hresp),
    .soft_irq    (soft_irq),
    .irq_lines   (irq_lines)
);

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

// Sixteen words at 0x100, seen through eight aliases
function automatic word_t window_addr(input logic [31:0] r);
    return (word_t'(r[18:16]) << 12) | 32'h0000_0100 | word_t'(r[5:0]);
endfunction

function automatic ahb_req_t make_req(input htrans_e trans, input logic [2:0] size,
                                      input logic write, input word_t addr);
    ahb_req_t req;
    req.trans = trans;
    req.size  = hsize_e'(size);
    req.write = write;
    req.addr  = addr;
    if (size == 3'd1) begin
        req.addr[0] = 1'b0;
    end else if (size == 3'd2) begin
        req.addr[1:0] = 2'b00;
    end
    return req;
endfunction

// One cycle: new address phases, write data for the previous one
task automatic step(input ahb_req_t dreq, input ahb_req_t ireq, input word_t wdata);
    @(posedge clk);
    #1;
    dmem_req    = dreq;
    imem_req    = ireq;
    dmem_hwdata = wdata_next;
    wdata_next  = wdata;
endtask

task automatic idle_steps(input int n);
    repeat (n) step('0, '0, next_rand());
endtask

task automatic run_random();
    logic [31:0] r;
    logic [31:0] a;
    htrans_e     trans;
    logic [2:0]  size;
    repeat (RANDOM_CYCLES) begin
        r = next_rand();
        a = next_rand();
        // Mostly NONSEQ, a few idle and unsupported transfers
        if (r[3:0] < 4'd12) begin
            trans = HTRANS_NONSEQ;
        end else if (r[3:0] < 4'd15) begin
            trans = HTRANS_IDLE;
        end else begin
            trans = r[4] ? HTRANS_BUSY : HTRANS_SEQ;
        end
        size = (r[6:5] == 2'd3) ? (r[7] ? 3'd2 : 3'd5) : {1'b0, r[6:5]};
        step(make_req(trans, size, r[8], window_addr(a)),
             make_req(r[9] ? HTRANS_NONSEQ : HTRANS_IDLE,
                      (r[11:10] == 2'd3) ? 3'd2 : {1'b0, r[11:10]}, r[12],
                      window_addr(a >> 8)),
             next_rand());
    end
endtask

task automatic run_forwarding();
    logic [31:0] r;
    word_t       addr;
    repeat (FWD_ROUNDS) begin
        r    = next_rand();
        addr = window_addr(next_rand());
        step(make_req(HTRANS_NONSEQ, (r[1:0] == 2'd3) ? 3'd2 : {1'b0, r[1:0]}, 1'b1, addr),
             '0, next_rand());
        // Both ports read the word during the write's data phase, imem via another alias
        step(make_req(HTRANS_NONSEQ, 3'd2, 1'b0, addr),
             make_req(HTRANS_NONSEQ, 3'd2, 1'b0, addr ^ 32'h0000_3000), next_rand());
    end
endtask

task automatic run_irq();
    repeat (IRQ_ROUNDS) begin
        step(make_req(HTRANS_NONSEQ, 3'd2, 1'b1, SOFT_IRQ_ADDR), '0, next_rand());
        step(make_req(HTRANS_NONSEQ, 3'd2, 1'b0, SOFT_IRQ_ADDR), '0, next_rand());
        step(make_req(HTRANS_NONSEQ, 3'd2, 1'b1, EXT_IRQ_ADDR), '0, next_rand());
        step(make_req(HTRANS_NONSEQ, 3'd2, 1'b0, EXT_IRQ_ADDR), '0, next_rand());
    end
endtask

task automatic run_errors();
    logic [31:0] r;
    word_t       addr;
    ahb_req_t    bad;
    repeat (ERR_ROUNDS) begin
        r    = next_rand();
        addr = window_addr(next_rand());
        step(make_req(HTRANS_NONSEQ, 3'd2, 1'b1, addr), '0, next_rand());
        case (r[1:0])
            2'd0:    bad = make_req(HTRANS_BUSY, 3'd2, 1'b1, addr);
            2'd1:    bad = make_req(HTRANS_SEQ, 3'd2, 1'b1, addr);
            default: bad = make_req(HTRANS_NONSEQ, {1'b1, r[3:2]}, 1'b1, addr);
        endcase
        step(bad, '0, next_rand());
        step(make_req(HTRANS_NONSEQ, 3'd2, 1'b0, addr),
             make_req(HTRANS_NONSEQ, 3'd2, 1'b0, addr), next_rand());
    end
endtask

// --------------------
// Test sequence
initial begin
    rng_state   = 32'h909f_6016;
    imem_req    = '0;
    dmem_req    = '0;
    dmem_hwdata = '0;
    wdata_next  = '0;
    @(posedge rst_n);
    idle_steps(IDLE_CYCLES + DRAIN_CYCLES);
    u_checker.report_test("reset_idle");
    run_random();
    idle_steps(DRAIN_CYCLES);
    u_checker.report_test("random");
    run_forwarding();
    idle_steps(DRAIN_CYCLES);
    u_checker.report_test("forwarding");
    run_irq();
    idle_steps(DRAIN_CYCLES);
    u_checker.report_test("irq_regs");
    run_errors();
    idle_steps(DRAIN_CYCLES);
    u_checker.report_test("errors");
    $display("total checks %0d errors %0d", u_checker.check_count, u_checker.error_count);
    if (u_checker.error_count == 0 && u_checker.check_count > 0) begin
        $display("=== PASS ===");
    end else begin
        $display("=== FAIL ===");
    end
    $finish;
end

initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, test sequence did not finish", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
end

endmodule

`default_nettype wire

//--- verification/tb_checker.sv
/*
 * Testbench checker for the dual-port AHB memory.
 * Byte model with known flags plus register copies; predicts every
 * data phase and compares the DUT responses and interrupt outputs.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  ahb_mem_pkg::ahb_req_t                 imem_req,
    input  ahb_mem_pkg::ahb_req_t                 dmem_req,
    input  ahb_mem_pkg::word_t                    dmem_hwdata,
    input  ahb_mem_pkg::word_t                    imem_hrdata,
    input  logic                                  imem_hresp,
    input  ahb_mem_pkg::word_t                    dmem_hrdata,
    input  logic                                  dmem_hresp,
    input  logic                                  soft_irq,
    input  logic [ahb_mem_pkg::IRQ_LINES_NUM-1:0] irq_lines
);

import ahb_mem_pkg::*;

typedef struct packed {
    logic  hresp;
    word_t hrdata;
    word_t cmp_mask;
} resp_t;

typedef struct packed {
    logic                     en;
    target_e                  target;
    logic [MEM_ADDR_BITS-1:0] base;
    be_t                      be;
} wr_t;

logic [7:0]               mem_model [2**MEM_ADDR_BITS];
logic                     known [2**MEM_ADDR_BITS];
logic                     soft_model;
logic [IRQ_LINES_NUM-1:0] ext_model;
resp_t                    imem_exp;
resp_t                    dmem_exp;
wr_t                      wr_pend;
int                       check_count;
int                       error_count;
int                       last_checks;
int                       last_errors;

initial begin
    check_count = 0;
    error_count = 0;
    last_checks = 0;
    last_errors = 0;
    for (int a = 0; a < 2**MEM_ADDR_BITS; a++) begin
        known[a] = 1'b0;
    end
end

// Lane i is selected when it lies inside the addressed byte, half or word
function automatic be_t lane_enables(input hsize_e size, input logic [1:0] low);
    be_t be;
    for (int i = 0; i < BYTE_LANES; i++) begin
        case (size)
            HSIZE_BYTE: be[i] = (i == low);
            HSIZE_HALF: be[i] = ((i / 2) == low[1]);
            default:    be[i] = 1'b1;
        endcase
    end
    return be;
endfunction

function automatic resp_t idle_resp();
    resp_t r;
    r.hresp    = HRESP_OKAY;
    r.hrdata   = '0;
    r.cmp_mask = '1;
    return r;
endfunction

task automatic check_word(input string name, input word_t actual, input word_t expected,
                          input word_t mask);
    check_count++;
    if ((actual & mask) !== (expected & mask)) begin
        error_count++;
        $display("MISMATCH %s: got %h expected %h (mask %h) at %0t ns",
                 name, actual, expected, mask, $time);
    end
endtask

// Expected data phase for one address phase, model already holds older writes
task automatic predict(input ahb_req_t req, input bit data_port, output resp_t resp,
                       output wr_t wr);
    be_t                      be;
    target_e                  target;
    logic [MEM_ADDR_BITS-1:0] base;
    resp = idle_resp();
    wr   = '0;
    be   = lane_enables(req.size, req.addr[1:0]);
    base = {req.addr[MEM_ADDR_BITS-1:2], 2'b00};
    target = TARGET_MEM;
    if (data_port && req.addr == SOFT_IRQ_ADDR) begin
        target = TARGET_SOFT_IRQ;
    end else if (data_port && req.addr == EXT_IRQ_ADDR) begin
        target = TARGET_EXT_IRQ;
    end
    if (req.trans == HTRANS_IDLE) begin
        resp = idle_resp();
    end else if (req.trans != HTRANS_NONSEQ || req.size > HSIZE_WORD) begin
        resp.hresp = HRESP_ERROR;
    end else if (data_port && req.write) begin
        wr.en     = 1'b1;
        wr.target = target;
        wr.base   = base;
        wr.be     = be;
    end else begin
        for (int i = 0; i < BYTE_LANES; i++) begin
            if (!be[i]) begin
                continue;
            end
            if (target == TARGET_SOFT_IRQ) begin
                resp.hrdata[8*i +: 8] = word_t'(soft_model) >> (8 * i);
            end else if (target == TARGET_EXT_IRQ) begin
                resp.hrdata[8*i +: 8] = word_t'(ext_model) >> (8 * i);
            end else if (known[base + i]) begin
                resp.hrdata[8*i +: 8] = mem_model[base + i];
            end else begin
                // Never written, value is free
                resp.cmp_mask[8*i +: 8] = 8'h00;
            end
        end
    end
endtask

task automatic apply_write(input wr_t wr, input word_t wdata);
    if (wr.en && wr.target == TARGET_SOFT_IRQ) begin
        soft_model = wdata[0];
    end else if (wr.en && wr.target == TARGET_EXT_IRQ) begin
        ext_model = wdata[IRQ_LINES_NUM-1:0];
    end else if (wr.en) begin
        for (int i = 0; i < BYTE_LANES; i++) begin
            if (wr.be[i]) begin
                mem_model[wr.base + i] = wdata[8*i +: 8];
                known[wr.base + i]     = 1'b1;
            end
        end
    end
endtask

// --------------------
// Sampled mid-cycle, when inputs and responses are settled
always @(negedge clk) begin
    wr_t imem_wr;
    if (!rst_n) begin
        soft_model = 1'b0;
        ext_model  = '0;
        imem_exp   = idle_resp();
        dmem_exp   = idle_resp();
        wr_pend    = '0;
    end else begin
        check_word("imem_hresp", word_t'(imem_hresp), word_t'(imem_exp.hresp), '1);
        check_word("imem_hrdata", imem_hrdata, imem_exp.hrdata, imem_exp.cmp_mask);
        check_word("dmem_hresp", word_t'(dmem_hresp), word_t'(dmem_exp.hresp), '1);
        check_word("dmem_hrdata", dmem_hrdata, dmem_exp.hrdata, dmem_exp.cmp_mask);
        check_word("soft_irq", word_t'(soft_irq), word_t'(soft_model), '1);
        check_word("irq_lines", word_t'(irq_lines), word_t'(ext_model), '1);
        apply_write(wr_pend, dmem_hwdata);
        predict(imem_req, 1'b0, imem_exp, imem_wr);
        predict(dmem_req, 1'b1, dmem_exp, wr_pend);
    end
end

task automatic report_test(input string name);
    $display("test %-12s checks %0d errors %0d", name,
             check_count - last_checks, error_count - last_errors);
    last_checks = check_count;
    last_errors = error_count;
endtask

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
/*
 * Testbench clock and reset source.
 * 4 ns clock, reset held low over the first four rising edges.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

// Released just after an edge, like the other inputs
initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
end

endmodule

`default_nettype wire

//--- hdl/ahb_dual_mem.sv
/*
 * Dual-port AHB-Lite memory top level.
 * Read-only instruction port, read/write data port, simulation IRQ registers.
 */
`timescale 1ns/1ps
`default_nettype none

module ahb_dual_mem (
    input  logic                                  clk,
    input  logic                                  rst_n,

    // Instruction port
    input  ahb_mem_pkg::ahb_req_t                 imem_req,
    output ahb_mem_pkg::word_t                    imem_hrdata,
    output logic                                  imem_hresp,

    // Data port
    input  ahb_mem_pkg::ahb_req_t                 dmem_req,
    input  ahb_mem_pkg::word_t                    dmem_hwdata,
    output ahb_mem_pkg::word_t                    dmem_hrdata,
    output logic                                  dmem_hresp,

    // Interrupts
    output logic                                  soft_irq,
    output logic [ahb_mem_pkg::IRQ_LINES_NUM-1:0] irq_lines
);

import ahb_mem_pkg::*;

phase_t dmem_phase;
word_t  imem_mem_rdata;
word_t  dmem_mem_rdata;
word_t  dmem_rdata;

// --------------------
// Port controllers
// --------------------

// Instruction context stays inside its controller
ahb_port_ctrl #(
    .HAS_WRITE (1'b0)
) u_imem_ctrl (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (imem_req),
    .rdata  (imem_mem_rdata),
    .phase  (),
    .hrdata (imem_hrdata),
    .hresp  (imem_hresp)
);

ahb_port_ctrl #(
    .HAS_WRITE (1'b1)
) u_dmem_ctrl (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (dmem_req),
    .rdata  (dmem_rdata),
    .phase  (dmem_phase),
    .hrdata (dmem_hrdata),
    .hresp  (dmem_hresp)
);

// --------------------
// Storage
// --------------------
byte_lane_memory u_mem (
    .clk        (clk),
    .imem_addr  (imem_req.addr),
    .dmem_addr  (dmem_req.addr),
    .dmem_phase (dmem_phase),
    .hwdata     (dmem_hwdata),
    .imem_rdata (imem_mem_rdata),
    .dmem_rdata (dmem_mem_rdata)
);

sim_irq_regs u_irq (
    .clk       (clk),
    .rst_n     (rst_n),
    .dmem_addr (dmem_req.addr),
    .phase     (dmem_phase),
    .hwdata    (dmem_hwdata),
    .mem_rdata (dmem_mem_rdata),
    .rdata     (dmem_rdata),
    .soft_irq  (soft_irq),
    .irq_lines (irq_lines)
);

endmodule

`default_nettype wire

//--- hdl/sim_irq_regs.sv
/*
 * Simulation interrupt registers on the data port.
 * Soft IRQ bit and external IRQ lines, merged into the read path.
 */
`timescale 1ns/1ps
`default_nettype none

module sim_irq_regs (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  ahb_mem_pkg::word_t                   dmem_addr,
    input  ahb_mem_pkg::phase_t                  phase,
    input  ahb_mem_pkg::word_t                   hwdata,
    input  ahb_mem_pkg::word_t                   mem_rdata,
    output ahb_mem_pkg::word_t                   rdata,
    output logic                                 soft_irq,
    output logic [ahb_mem_pkg::IRQ_LINES_NUM-1:0] irq_lines
);

import ahb_mem_pkg::*;

logic  reg_wr;
logic  soft_wr;
logic  ext_wr;
word_t soft_word;
word_t ext_word;
word_t reg_word_q;

// --------------------
// Register writes
// --------------------
assign reg_wr  = phase.valid && phase.write && !phase.err;
assign soft_wr = reg_wr && (phase.target == TARGET_SOFT_IRQ);
assign ext_wr  = reg_wr && (phase.target == TARGET_EXT_IRQ);

always_ff @(posedge clk) begin
    if (!rst_n) begin
        soft_irq  <= 1'b0;
        irq_lines <= '0;
    end else begin
        if (soft_wr) begin
            soft_irq <= hwdata[0];
        end
        if (ext_wr) begin
            irq_lines <= hwdata[IRQ_LINES_NUM-1:0];
        end
    end
end

// --------------------
// Register reads
// --------------------

// Pending write folded in, same as RAM forwarding
assign soft_word = word_t'(soft_wr ? hwdata[0] : soft_irq);
assign ext_word  = word_t'(ext_wr ? hwdata[IRQ_LINES_NUM-1:0] : irq_lines);

// Sampled in the address phase
always_ff @(posedge clk) begin
    if (dmem_addr == SOFT_IRQ_ADDR) begin
        reg_word_q <= soft_word;
    end else if (dmem_addr == EXT_IRQ_ADDR) begin
        reg_word_q <= ext_word;
    end else begin
        reg_word_q <= '0;
    end
end

assign rdata = (phase.target == TARGET_MEM) ? mem_rdata : reg_word_q;

endmodule

`default_nettype wire

//--- hdl/byte_lane_memory.sv
/*
 * Byte-lane RAM with one write port and two read ports.
 * Reads are registered and pick up lanes of a pending write to the same word.
 */
`timescale 1ns/1ps
`default_nettype none

module byte_lane_memory (
    input  logic                clk,
    input  ahb_mem_pkg::word_t  imem_addr,
    input  ahb_mem_pkg::word_t  dmem_addr,
    input  ahb_mem_pkg::phase_t dmem_phase,
    input  ahb_mem_pkg::word_t  hwdata,
    output ahb_mem_pkg::word_t  imem_rdata,
    output ahb_mem_pkg::word_t  dmem_rdata
);

import ahb_mem_pkg::*;

logic                      wr_en;
logic [WORD_ADDR_BITS-1:0] imem_word;
logic [WORD_ADDR_BITS-1:0] dmem_word;
logic                      imem_hit;
logic                      dmem_hit;

// --------------------
// Write and hazard detect
// --------------------

// Data-phase write into RAM space only
assign wr_en = dmem_phase.valid
             && dmem_phase.write
             && !dmem_phase.err
             && (dmem_phase.target == TARGET_MEM);

// Upper address bits are ignored, memory aliases
assign imem_word = imem_addr[MEM_ADDR_BITS-1:2];
assign dmem_word = dmem_addr[MEM_ADDR_BITS-1:2];

// Read in its address phase against a write in its data phase
assign imem_hit = wr_en && (imem_word == dmem_phase.word_addr);
assign dmem_hit = wr_en && (dmem_word == dmem_phase.word_addr);

// --------------------
// Lanes
// --------------------
for (genvar i = 0; i < BYTE_LANES; i++) begin : g_lane
    logic [7:0] ram [MEM_DEPTH];
    logic [7:0] wr_byte;
    logic       imem_fwd;
    logic       dmem_fwd;
    logic [7:0] imem_q;
    logic [7:0] dmem_q;

    assign wr_byte  = hwdata[8*i +: 8];
    assign imem_fwd = imem_hit && dmem_phase.be[i];
    assign dmem_fwd = dmem_hit && dmem_phase.be[i];

    always_ff @(posedge clk) begin
        if (wr_en && dmem_phase.be[i]) begin
            ram[dmem_phase.word_addr] <= wr_byte;
        end
    end

    // Registered reads, new byte wins on a hit
    always_ff @(posedge clk) begin
        imem_q <= imem_fwd ? wr_byte : ram[imem_word];
        dmem_q <= dmem_fwd ? wr_byte : ram[dmem_word];
    end

    assign imem_rdata[8*i +: 8] = imem_q;
    assign dmem_rdata[8*i +: 8] = dmem_q;
end

endmodule

`default_nettype wire

//--- hdl/ahb_port_ctrl.sv
/*
 * AHB-Lite port controller.
 * Decodes the address phase into a registered data-phase context
 * and forms HRESP and lane-masked HRDATA during the data phase.
 */
`timescale 1ns/1ps
`default_nettype none

module ahb_port_ctrl #(
    parameter bit HAS_WRITE = 1'b1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ahb_mem_pkg::ahb_req_t req,
    input  ahb_mem_pkg::word_t    rdata,
    output ahb_mem_pkg::phase_t   phase,
    output ahb_mem_pkg::word_t    hrdata,
    output logic                  hresp
);

import ahb_mem_pkg::*;

be_t     be_next;
logic    size_ok;
logic    valid_next;
logic    err_next;
logic    write_next;
target_e target_next;
word_t   lane_mask;

// --------------------
// Address phase decode
// --------------------

// Byte enables from size and low address bits
always_comb begin
    be_next = '0;
    size_ok = 1'b1;
    case (req.size)
        HSIZE_BYTE: begin
            be_next = be_t'(1) << req.addr[1:0];
        end
        HSIZE_HALF: begin
            be_next = req.addr[1] ? 4'b1100 : 4'b0011;
        end
        HSIZE_WORD: begin
            be_next = '1;
        end
        default: begin
            size_ok = 1'b0;
        end
    endcase
end

// Only NONSEQ with a legal size is a good transfer
always_comb begin
    valid_next = 1'b0;
    err_next   = 1'b0;
    case (req.trans)
        HTRANS_IDLE: begin
            // No transfer, OKAY data phase
            valid_next = 1'b0;
        end
        HTRANS_NONSEQ: begin
            valid_next = 1'b1;
            err_next   = ~size_ok;
        end
        default: begin
            // BUSY and SEQ are not supported
            valid_next = 1'b1;
            err_next   = 1'b1;
        end
    endcase
end

if (HAS_WRITE) begin : g_write
    // Register targets are matched on the full address
    always_comb begin
        write_next = req.write;
        if (req.addr == SOFT_IRQ_ADDR) begin
            target_next = TARGET_SOFT_IRQ;
        end else if (req.addr == EXT_IRQ_ADDR) begin
            target_next = TARGET_EXT_IRQ;
        end else begin
            target_next = TARGET_MEM;
        end
    end
end else begin : g_read_only
    assign write_next  = 1'b0;
    assign target_next = TARGET_MEM;
end

// Data phase context, updated every cycle
always_ff @(posedge clk) begin
    if (!rst_n) begin
        phase <= '0;
    end else begin
        phase.valid     <= valid_next;
        phase.err       <= err_next;
        phase.write     <= write_next;
        phase.target    <= target_next;
        phase.word_addr <= req.addr[MEM_ADDR_BITS-1:2];
        phase.be        <= be_next;
    end
end

// --------------------
// Data phase response
// --------------------
always_comb begin
    lane_mask = '0;
    for (int i = 0; i < BYTE_LANES; i++) begin
        lane_mask[8*i +: 8] = {8{phase.be[i]}};
    end
end

assign hresp = (phase.valid && phase.err) ? HRESP_ERROR : HRESP_OKAY;

// Zero for idle, error and write data phases
assign hrdata = (phase.valid && !phase.err && !phase.write) ? (rdata & lane_mask) : '0;

endmodule

`default_nettype wire

//--- hdl/ahb_mem_pkg.sv
/*
 * AHB dual-port memory shared definitions.
 * Widths, bus codes, register map and transfer context types.
 */
`default_nettype none

package ahb_mem_pkg;

// --------------------
// Widths and sizes
// --------------------
localparam int AHB_WIDTH      = 32;
localparam int BYTE_LANES     = AHB_WIDTH / 8;
localparam int MEM_ADDR_BITS  = 12;
localparam int WORD_ADDR_BITS = MEM_ADDR_BITS - 2;
localparam int MEM_DEPTH      = 2 ** WORD_ADDR_BITS;
localparam int IRQ_LINES_NUM  = 16;

// Register map, matched on the full address
localparam logic [AHB_WIDTH-1:0] SOFT_IRQ_ADDR = 32'hF000_0000;
localparam logic [AHB_WIDTH-1:0] EXT_IRQ_ADDR  = 32'hF000_0100;

// HRESP codes
localparam logic HRESP_OKAY  = 1'b0;
localparam logic HRESP_ERROR = 1'b1;

// --------------------
// Types
// --------------------
typedef logic [AHB_WIDTH-1:0]  word_t;
typedef logic [BYTE_LANES-1:0] be_t;

typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
} htrans_e;

// Only the three sizes below are legal
typedef enum logic [2:0] {
    HSIZE_BYTE = 3'b000,
    HSIZE_HALF = 3'b001,
    HSIZE_WORD = 3'b010
} hsize_e;

typedef enum logic [1:0] {
    TARGET_MEM      = 2'b00,
    TARGET_SOFT_IRQ = 2'b01,
    TARGET_EXT_IRQ  = 2'b10
} target_e;

// Address-phase inputs of one port
typedef struct packed {
    htrans_e trans;
    hsize_e  size;
    logic    write;
    word_t   addr;
} ahb_req_t;

// Context carried from address phase into data phase
typedef struct packed {
    logic                      valid;
    logic                      err;
    logic                      write;
    target_e                   target;
    logic [WORD_ADDR_BITS-1:0] word_addr;
    be_t                       be;
} phase_t;

endpackage

`default_nettype wire
